/* verilog/backend_params.svh */
// back-end width parameters
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// integer data width
`define XLEN 64

// rename copies per architectural register
`define RNDEPTH 4
`define RNBIT 2

// architectural register file
`define ARCH_REGS 32
`define ARCH_BIT 5

// physical register file, index is {arch, copy}
`define PHYS_REGS (`ARCH_REGS * `RNDEPTH)
`define PHYS_BIT (`ARCH_BIT + `RNBIT)

// shift amount taken from op_b
`define SHAMT_BIT 6

`endif

/* verilog/regfile_pkg.sv */
// physical register file types
`default_nettype none

`include "backend_params.svh"

package regfile_pkg;

	// arch register times RNDEPTH plus copy
	typedef logic [`PHYS_BIT-1:0] phys_idx_t;

	// clears the write-back log bit of idx
	typedef struct packed {
		logic      valid;
		phys_idx_t idx;
	} alloc_t;

	typedef struct packed {
		phys_idx_t idx;
	} read_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] data;
		logic             written;
	} read_resp_t;

endpackage

`default_nettype wire

/* verilog/exec_pkg.sv */
// execution unit opcodes and structs
`default_nettype none

`include "backend_params.svh"

package exec_pkg;

	typedef enum logic {
		ADD = 1'b0,
		SUB = 1'b1
	} alu_op_e;

	typedef enum logic [2:0] {
		AND  = 3'd0,
		OR   = 3'd1,
		XOR  = 3'd2,
		SLT  = 3'd3,
		SLTU = 3'd4
	} logic_op_e;

	typedef enum logic [1:0] {
		SLL = 2'd0,
		SRL = 2'd1,
		SRA = 2'd2
	} shift_op_e;

	// operands arrive already read
	typedef struct packed {
		logic                  valid;
		alu_op_e               op;
		logic [`XLEN-1:0]      op_a;
		logic [`XLEN-1:0]      op_b;
		regfile_pkg::phys_idx_t rd;
	} adder_issue_t;

	typedef struct packed {
		logic                  valid;
		logic_op_e             op;
		logic [`XLEN-1:0]      op_a;
		logic [`XLEN-1:0]      op_b;
		regfile_pkg::phys_idx_t rd;
	} logic_issue_t;

	typedef struct packed {
		logic                  valid;
		shift_op_e             op;
		logic [`XLEN-1:0]      op_a;
		logic [`XLEN-1:0]      op_b;
		regfile_pkg::phys_idx_t rd;
	} shift_issue_t;

	// what every unit hands to write-back
	typedef struct packed {
		logic                  valid;
		regfile_pkg::phys_idx_t rd;
		logic [`XLEN-1:0]      res;
	} wb_result_t;

endpackage

`default_nettype wire

/* verilog/int_adder.sv */
// integer add/subtract unit
`default_nettype none

`include "backend_params.svh"

module int_adder (
	input  logic                  clk,
	input  logic                  reset,
	input  exec_pkg::adder_issue_t issue,
	output exec_pkg::wb_result_t   result
);

	logic                   is_sub;
	logic [`XLEN-1:0]       op_b_inv;
	logic [`XLEN-1:0]       sum;

	logic                   valid_q;
	regfile_pkg::phys_idx_t rd_q;
	logic [`XLEN-1:0]       res_q;

	// subtract as a + ~b + 1, one carry chain
	assign is_sub   = (issue.op == exec_pkg::SUB);
	assign op_b_inv = issue.op_b ^ {`XLEN{is_sub}};
	assign sum      = issue.op_a + op_b_inv + {{(`XLEN-1){1'b0}}, is_sub};

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue.valid;
		end
	end

	always_ff @(posedge clk) begin
		rd_q  <= issue.rd;
		res_q <= sum;
	end

	assign result = '{valid: valid_q, rd: rd_q, res: res_q};

endmodule

`default_nettype wire

/* verilog/int_logic_compare.sv */
// integer logic and compare unit
`default_nettype none

`include "backend_params.svh"

module int_logic_compare (
	input  logic                  clk,
	input  logic                  reset,
	input  exec_pkg::logic_issue_t issue,
	output exec_pkg::wb_result_t   result
);

	logic                   lt_signed;
	logic                   lt_unsigned;
	logic [`XLEN-1:0]       res_d;

	logic                   valid_q;
	regfile_pkg::phys_idx_t rd_q;
	logic [`XLEN-1:0]       res_q;

	assign lt_signed   = ($signed(issue.op_a) < $signed(issue.op_b));
	assign lt_unsigned = (issue.op_a < issue.op_b);

	always_comb begin
		case (issue.op)
			exec_pkg::AND:  res_d = issue.op_a & issue.op_b;
			exec_pkg::OR:   res_d = issue.op_a | issue.op_b;
			exec_pkg::XOR:  res_d = issue.op_a ^ issue.op_b;
			// compare results zero-extend to a full word
			exec_pkg::SLT:  res_d = {{(`XLEN-1){1'b0}}, lt_signed};
			exec_pkg::SLTU: res_d = {{(`XLEN-1){1'b0}}, lt_unsigned};
			default:        res_d = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue.valid;
		end
	end

	always_ff @(posedge clk) begin
		rd_q  <= issue.rd;
		res_q <= res_d;
	end

	assign result = '{valid: valid_q, rd: rd_q, res: res_q};

endmodule

`default_nettype wire

/* verilog/int_shifter.sv */
// integer shift unit
`default_nettype none

`include "backend_params.svh"

module int_shifter (
	input  logic                  clk,
	input  logic                  reset,
	input  exec_pkg::shift_issue_t issue,
	output exec_pkg::wb_result_t   result
);

	logic [`SHAMT_BIT-1:0]  shamt;
	logic signed [`XLEN-1:0] op_a_s;
	logic [`XLEN-1:0]       res_d;

	logic                   valid_q;
	regfile_pkg::phys_idx_t rd_q;
	logic [`XLEN-1:0]       res_q;

	// only the low bits of op_b count
	assign shamt  = issue.op_b[`SHAMT_BIT-1:0];
	assign op_a_s = issue.op_a;

	always_comb begin
		case (issue.op)
			exec_pkg::SLL: res_d = issue.op_a << shamt;
			exec_pkg::SRL: res_d = issue.op_a >> shamt;
			// sign fill from bit XLEN-1
			exec_pkg::SRA: res_d = op_a_s >>> shamt;
			default:       res_d = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue.valid;
		end
	end

	always_ff @(posedge clk) begin
		rd_q  <= issue.rd;
		res_q <= res_d;
	end

	assign result = '{valid: valid_q, rd: rd_q, res: res_q};

endmodule

`default_nettype wire

/* verilog/write_back.sv */
// result merge into the register file
`default_nettype none

`include "backend_params.svh"

module write_back (
	input  exec_pkg::wb_result_t              adder_res,
	input  exec_pkg::wb_result_t              logic_res,
	input  exec_pkg::wb_result_t              shift_res,
	input  logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_qout,
	output logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_dnxt,
	output logic [`PHYS_REGS-1:0]             wb_log_set
);

	// arch register 0 copies are hard zero and always produced
	for (genvar copy = 0; copy < `RNDEPTH; copy = copy + 1) begin : g_zero
		assign regfile_dnxt[copy] = '0;
		assign wb_log_set[copy]   = 1'b1;
	end

	for (genvar arch = 1; arch < `ARCH_REGS; arch = arch + 1) begin : g_arch
		for (genvar copy = 0; copy < `RNDEPTH; copy = copy + 1) begin : g_copy
			localparam int SEL = arch * `RNDEPTH + copy;

			logic hit_adder;
			logic hit_logic;
			logic hit_shift;
			logic hit_any;

			assign hit_adder = adder_res.valid &
				(adder_res.rd == regfile_pkg::phys_idx_t'(SEL));
			assign hit_logic = logic_res.valid &
				(logic_res.rd == regfile_pkg::phys_idx_t'(SEL));
			assign hit_shift = shift_res.valid &
				(shift_res.rd == regfile_pkg::phys_idx_t'(SEL));
			assign hit_any   = hit_adder | hit_logic | hit_shift;

			// at most one unit hits a given index per cycle, so OR is a mux
			assign regfile_dnxt[SEL] =
				({`XLEN{hit_adder}} & adder_res.res) |
				({`XLEN{hit_logic}} & logic_res.res) |
				({`XLEN{hit_shift}} & shift_res.res) |
				({`XLEN{~hit_any}}  & regfile_qout[SEL]);

			assign wb_log_set[SEL] = hit_any;
		end
	end

endmodule

`default_nettype wire

/* verilog/phys_regfile.sv */
// physical register file and write-back log
`default_nettype none

`include "backend_params.svh"

module phys_regfile (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_dnxt,
	input  logic [`PHYS_REGS-1:0]             wb_log_set,
	input  regfile_pkg::alloc_t               alloc,
	output logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_qout,
	input  regfile_pkg::read_req_t            read_req,
	output regfile_pkg::read_resp_t           read_resp
);

	logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_q;
	logic [`PHYS_REGS-1:0]             log_q;
	logic [`PHYS_REGS-1:0]             alloc_clr;

	// one-hot clear from the allocation pulse
	assign alloc_clr = alloc.valid ?
		(`PHYS_REGS'(1) << alloc.idx) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			regfile_q <= '0;
		end else begin
			regfile_q <= regfile_dnxt;
		end
	end

	// set wins over clear
	always_ff @(posedge clk) begin
		if (reset) begin
			log_q <= {{(`PHYS_REGS-`RNDEPTH){1'b0}}, {`RNDEPTH{1'b1}}};
		end else begin
			log_q <= wb_log_set | (log_q & ~alloc_clr);
		end
	end

	assign regfile_qout = regfile_q;

	// observation port, combinational
	assign read_resp.data    = regfile_q[read_req.idx];
	assign read_resp.written = log_q[read_req.idx];

endmodule

`default_nettype wire

/* verilog/exec_backend.sv */
// integer execution back-end
`default_nettype none

`include "backend_params.svh"

module exec_backend (
	input  logic                    clk,
	input  logic                    reset,
	input  exec_pkg::adder_issue_t  adder_issue,
	input  exec_pkg::logic_issue_t  logic_issue,
	input  exec_pkg::shift_issue_t  shift_issue,
	input  regfile_pkg::alloc_t     alloc,
	input  regfile_pkg::read_req_t  read_req,
	output regfile_pkg::read_resp_t read_resp
);

	exec_pkg::wb_result_t              adder_res;
	exec_pkg::wb_result_t              logic_res;
	exec_pkg::wb_result_t              shift_res;

	logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_qout;
	logic [`PHYS_REGS-1:0][`XLEN-1:0] regfile_dnxt;
	logic [`PHYS_REGS-1:0]             wb_log_set;

	int_adder u_int_adder (
		.clk    (clk),
		.reset  (reset),
		.issue  (adder_issue),
		.result (adder_res)
	);

	int_logic_compare u_int_logic_compare (
		.clk    (clk),
		.reset  (reset),
		.issue  (logic_issue),
		.result (logic_res)
	);

	int_shifter u_int_shifter (
		.clk    (clk),
		.reset  (reset),
		.issue  (shift_issue),
		.result (shift_res)
	);

	// merge is combinational, lands in the register file one edge later
	write_back u_write_back (
		.adder_res    (adder_res),
		.logic_res    (logic_res),
		.shift_res    (shift_res),
		.regfile_qout (regfile_qout),
		.regfile_dnxt (regfile_dnxt),
		.wb_log_set   (wb_log_set)
	);

	phys_regfile u_phys_regfile (
		.clk          (clk),
		.reset        (reset),
		.regfile_dnxt (regfile_dnxt),
		.wb_log_set   (wb_log_set),
		.alloc        (alloc),
		.regfile_qout (regfile_qout),
		.read_req     (read_req),
		.read_resp    (read_resp)
	);

endmodule

`default_nettype wire

/* verification/exec_backend_tb.sv */
// exec back-end testbench
`default_nettype none

`include "backend_params.svh"

module exec_backend_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int N_ADD = 40;
	localparam int N_LOGIC = 40;
	localparam int N_SHIFT = 40;
	localparam int N_MIX = 16;
	localparam int N_ALLOC = 8;
	localparam int TOTAL_OPS = N_ADD + N_LOGIC + N_SHIFT + 3 * N_MIX + N_ALLOC;
	// issue plus check cycle per op and room for the full sweeps
	localparam int WATCHDOG_CYCLES = TOTAL_OPS * 3 + 3 * `PHYS_REGS + 100;

	logic                    clk;
	logic                    reset;
	exec_pkg::adder_issue_t  adder_issue;
	exec_pkg::logic_issue_t  logic_issue;
	exec_pkg::shift_issue_t  shift_issue;
	regfile_pkg::alloc_t     alloc;
	regfile_pkg::read_req_t  read_req;
	regfile_pkg::read_resp_t read_resp;

	// settled state once every issued op has drained
	logic [`XLEN-1:0] model_data [`PHYS_REGS];
	logic             model_log [`PHYS_REGS];

	// compare strobe and expected response set on a rising edge
	logic                    chk_en;
	regfile_pkg::read_resp_t exp_resp;

	logic [63:0]            lcg_state;
	int                     error_count;
	int                     check_count;
	int                     test_errors;
	int                     tests_passed;
	int                     tests_failed;
	regfile_pkg::phys_idx_t touched [$];

	exec_backend u_exec_backend (
		.clk         (clk),
		.reset       (reset),
		.adder_issue (adder_issue),
		.logic_issue (logic_issue),
		.shift_issue (shift_issue),
		.alloc       (alloc),
		.read_req    (read_req),
		.read_resp   (read_resp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// read port sampled at the falling edge away from input changes
	read_matches: assert property (@(negedge clk) disable iff (reset)
		chk_en |-> (read_resp == exp_resp))
	else begin
		error_count++;
		$display("error at %0t ns: phys reg %0d reads %h/%0b, expected %h/%0b",
			$time, read_req.idx, read_resp.data, read_resp.written,
			exp_resp.data, exp_resp.written);
	end

	function logic [63:0] lcg_next();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state;
	endfunction

	// low LCG bits are weak so take upper halves
	function logic [`XLEN-1:0] random_word();
		logic [63:0] hi;
		logic [63:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[63:32], lo[63:32]};
	endfunction

	function int unsigned pick_below(int unsigned n);
		logic [63:0] r;
		r = lcg_next();
		return r[63:32] % n;
	endfunction

	// any arch register but 0
	function regfile_pkg::phys_idx_t pick_rd(int unsigned copy);
		int unsigned arch;
		arch = 1 + pick_below(`ARCH_REGS - 1);
		return regfile_pkg::phys_idx_t'(arch * `RNDEPTH + copy);
	endfunction

	function exec_pkg::adder_issue_t new_add_issue(regfile_pkg::phys_idx_t rd);
		exec_pkg::adder_issue_t a;
		a.valid = 1'b1;
		a.op    = exec_pkg::alu_op_e'(pick_below(2));
		a.op_a  = random_word();
		a.op_b  = random_word();
		a.rd    = rd;
		return a;
	endfunction

	function exec_pkg::logic_issue_t new_logic_issue(regfile_pkg::phys_idx_t rd);
		exec_pkg::logic_issue_t l;
		l.valid = 1'b1;
		l.op    = exec_pkg::logic_op_e'(pick_below(5));
		l.op_a  = random_word();
		l.op_b  = random_word();
		l.rd    = rd;
		return l;
	endfunction

	function exec_pkg::shift_issue_t new_shift_issue(regfile_pkg::phys_idx_t rd);
		exec_pkg::shift_issue_t s;
		s.valid = 1'b1;
		s.op    = exec_pkg::shift_op_e'(pick_below(3));
		s.op_a  = random_word();
		s.op_b  = random_word();
		s.rd    = rd;
		return s;
	endfunction

	function logic [`XLEN-1:0] add_result(exec_pkg::alu_op_e op, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b);
		if (op == exec_pkg::SUB)
			return a - b;
		return a + b;
	endfunction

	function logic [`XLEN-1:0] logic_result(exec_pkg::logic_op_e op, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b);
		logic below;
		// with opposite signs the negative one is smaller
		below = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
		case (op)
			exec_pkg::AND:  return a & b;
			exec_pkg::OR:   return a | b;
			exec_pkg::XOR:  return a ^ b;
			exec_pkg::SLT:  return `XLEN'(below);
			exec_pkg::SLTU: return `XLEN'(a < b);
			default:        return '0;
		endcase
	endfunction

	function logic [`XLEN-1:0] shift_result(exec_pkg::shift_op_e op, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b);
		logic [`SHAMT_BIT-1:0] sh;
		logic [`XLEN-1:0]      fill;
		sh   = b[`SHAMT_BIT-1:0];
		fill = ~({`XLEN{1'b1}} >> sh);
		case (op)
			exec_pkg::SLL: return a << sh;
			exec_pkg::SRL: return a >> sh;
			exec_pkg::SRA: return a[`XLEN-1] ? ((a >> sh) | fill) : (a >> sh);
			default:       return '0;
		endcase
	endfunction

	// arch register 0 never changes
	task automatic record_write(regfile_pkg::phys_idx_t rd, logic [`XLEN-1:0] value);
		if (rd / `RNDEPTH != 0) begin
			model_data[rd] = value;
			model_log[rd]  = 1'b1;
			touched.push_back(rd);
		end
	endtask

	task automatic issue_cycle(exec_pkg::adder_issue_t a, exec_pkg::logic_issue_t l,
			exec_pkg::shift_issue_t s);
		@(posedge clk);
		adder_issue <= a;
		logic_issue <= l;
		shift_issue <= s;
		if (a.valid)
			record_write(a.rd, add_result(a.op, a.op_a, a.op_b));
		if (l.valid)
			record_write(l.rd, logic_result(l.op, l.op_a, l.op_b));
		if (s.valid)
			record_write(s.rd, shift_result(s.op, s.op_a, s.op_b));
	endtask

	task automatic issue_idle(int cycles);
		repeat (cycles) begin
			@(posedge clk);
			adder_issue <= '0;
			logic_issue <= '0;
			shift_issue <= '0;
		end
	endtask

	task automatic check_idx(regfile_pkg::phys_idx_t idx);
		@(posedge clk);
		read_req <= '{idx: idx};
		exp_resp <= '{data: model_data[idx], written: model_log[idx]};
		chk_en   <= 1'b1;
		check_count++;
	endtask

	task automatic check_done();
		@(posedge clk);
		chk_en <= 1'b0;
	endtask

	task automatic check_touched();
		foreach (touched[i])
			check_idx(touched[i]);
		check_done();
	endtask

	task automatic sweep_all();
		for (int i = 0; i < `PHYS_REGS; i++)
			check_idx(regfile_pkg::phys_idx_t'(i));
		check_done();
	endtask

	task automatic allocate(regfile_pkg::phys_idx_t idx);
		@(posedge clk);
		alloc <= '{valid: 1'b1, idx: idx};
		model_log[idx] = 1'b0;
	endtask

	task automatic start_test();
		test_errors = error_count;
		touched.delete();
	endtask

	task automatic end_test(string name);
		if (error_count == test_errors) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - test_errors);
		end
	endtask

	task automatic adder_test();
		exec_pkg::adder_issue_t a;
		start_test();
		// wrap cases at both ends of the range
		a = '{valid: 1'b1, op: exec_pkg::ADD, op_a: '1, op_b: `XLEN'(1), rd: pick_rd(0)};
		issue_cycle(a, '0, '0);
		a = '{valid: 1'b1, op: exec_pkg::SUB, op_a: '0, op_b: `XLEN'(1), rd: pick_rd(1)};
		issue_cycle(a, '0, '0);
		repeat (N_ADD)
			issue_cycle(new_add_issue(pick_rd(pick_below(`RNDEPTH))), '0, '0);
		issue_idle(2);
		check_touched();
		end_test("adder");
	endtask

	task automatic logic_test();
		exec_pkg::logic_issue_t l;
		start_test();
		// -1 against 1 splits signed from unsigned
		l = '{valid: 1'b1, op: exec_pkg::SLT, op_a: '1, op_b: `XLEN'(1), rd: pick_rd(0)};
		issue_cycle('0, l, '0);
		l = '{valid: 1'b1, op: exec_pkg::SLTU, op_a: '1, op_b: `XLEN'(1), rd: pick_rd(1)};
		issue_cycle('0, l, '0);
		repeat (N_LOGIC)
			issue_cycle('0, new_logic_issue(pick_rd(pick_below(`RNDEPTH))), '0);
		issue_idle(2);
		check_touched();
		end_test("logic and compare");
	endtask

	task automatic shifter_test();
		exec_pkg::shift_issue_t s;
		start_test();
		s = '{valid: 1'b1, op: exec_pkg::SRA, op_a: {1'b1, {(`XLEN-1){1'b0}}},
			op_b: `XLEN'(63), rd: pick_rd(2)};
		issue_cycle('0, '0, s);
		repeat (N_SHIFT)
			issue_cycle('0, '0, new_shift_issue(pick_rd(pick_below(`RNDEPTH))));
		issue_idle(2);
		check_touched();
		end_test("shifter");
	endtask

	task automatic mixed_test();
		start_test();
		// a fixed copy per unit keeps the three rds apart
		repeat (N_MIX)
			issue_cycle(new_add_issue(pick_rd(0)), new_logic_issue(pick_rd(1)),
				new_shift_issue(pick_rd(2)));
		issue_idle(2);
		sweep_all();
		end_test("mixed units");
	endtask

	task automatic alloc_test();
		start_test();
		for (int k = 0; k < N_ALLOC; k++)
			issue_cycle(new_add_issue(regfile_pkg::phys_idx_t'((k + 1) * `RNDEPTH + 3)),
				'0, '0);
		issue_idle(2);
		check_touched();
		foreach (touched[i])
			allocate(touched[i]);
		@(posedge clk);
		alloc <= '0;
		check_touched();
		// rewrite the allocated registers, the queue grows as they are recorded
		for (int i = 0; i < N_ALLOC; i++)
			issue_cycle(new_add_issue(touched[i]), '0, '0);
		issue_idle(2);
		check_touched();
		// every copy of arch register 0 stays zero
		issue_cycle(new_add_issue(0), new_logic_issue(1), new_shift_issue(2));
		issue_cycle(new_add_issue(3), '0, '0);
		issue_idle(2);
		for (int i = 0; i < `RNDEPTH; i++)
			check_idx(regfile_pkg::phys_idx_t'(i));
		check_done();
		end_test("allocation and zero register");
	endtask

	initial begin
		reset        = 1'b1;
		adder_issue  = '0;
		logic_issue  = '0;
		shift_issue  = '0;
		alloc        = '0;
		read_req     = '0;
		chk_en       = 1'b0;
		exp_resp     = '0;
		lcg_state    = 64'd99;
		error_count  = 0;
		check_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < `PHYS_REGS; i++) begin
			model_data[i] = '0;
			model_log[i]  = (i < `RNDEPTH);
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		start_test();
		sweep_all();
		end_test("reset state");
		adder_test();
		logic_test();
		shifter_test();
		mixed_test();
		alloc_test();

		$display("tests passed %0d, failed %0d, %0d checks, %0d errors",
			tests_passed, tests_failed, check_count, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/regfile_pkg.sv
verilog/exec_pkg.sv
verilog/int_adder.sv
verilog/int_logic_compare.sv
verilog/int_shifter.sv
verilog/write_back.sv
verilog/phys_regfile.sv
verilog/exec_backend.sv
verification/exec_backend_tb.sv

/* Bender.yml */
package:
  name: exec_backend

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/regfile_pkg.sv
      - verilog/exec_pkg.sv
      - verilog/int_adder.sv
      - verilog/int_logic_compare.sv
      - verilog/int_shifter.sv
      - verilog/write_back.sv
      - verilog/phys_regfile.sv
      - verilog/exec_backend.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/exec_backend_tb.sv
